// File: dm_top.f
hw/dm_pkg.sv
hw/abs_timer.sv
hw/hart_regfile.sv
hw/abs_cmd_fsm.sv
hw/dm_regs.sv
hw/dmi_front.sv
hw/dm_top.sv
verification/tb_dm_top.sv

// File: hw/abs_cmd_fsm.sv
// Abstract command engine. Checks an access register command, waits for
// the latency timer, then moves data between data0 and a hart register.
`timescale 1ns/10ps
`default_nettype none

module abs_cmd_fsm #(
  parameter int NumGprs = 8
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       cmd_valid,
  input  wire dm_pkg::abs_cmd_u           cmd,
  output logic                            busy,
  output logic                            err_valid,
  output dm_pkg::cmderr_e                 err_code,
  input  wire logic [31:0]                data0_q,
  output logic                            data0_we,
  output logic [31:0]                     data0_wdata,
  output logic                            start,
  input  wire logic                       done,
  output logic                            gpr_we,
  output logic [$clog2(NumGprs)-1:0]      gpr_waddr,
  output logic [31:0]                     gpr_wdata,
  output logic [$clog2(NumGprs)-1:0]      gpr_raddr,
  input  wire logic [31:0]                gpr_rdata
);

  localparam int AddrW = $clog2(NumGprs);

  typedef enum logic [1:0] {
    StIdle,
    StCheck,
    StWait,
    StExec
  } state_e;

  state_e           state_q;
  state_e           state_d;
  dm_pkg::abs_cmd_u cmd_q;
  logic             not_supported;
  logic             bad_regno;
  logic [15:0]      gpr_idx;
  logic             xfer;

  assign not_supported = (cmd_q.acc.cmdtype != 8'h0) || (cmd_q.acc.aarsize != 3'd2);
  assign bad_regno     = cmd_q.acc.transfer &&
                         ((cmd_q.acc.regno < dm_pkg::GprBase) ||
                          (cmd_q.acc.regno >= dm_pkg::GprBase + 16'(NumGprs)));
  assign gpr_idx       = cmd_q.acc.regno - dm_pkg::GprBase;

  always_comb begin
    state_d = state_q;
    case (state_q)
      StIdle:  if (cmd_valid) state_d = StCheck;
      StCheck: state_d = (not_supported || bad_regno) ? StIdle : StWait;
      StWait:  if (done) state_d = StExec;
      // exec is not busy, so a new command may already arrive here
      StExec:  state_d = cmd_valid ? StCheck : StIdle;
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid) begin
      cmd_q <= cmd;
    end
  end

  assign busy      = (state_q == StCheck) || (state_q == StWait);
  assign err_valid = (state_q == StCheck) && (not_supported || bad_regno);
  assign err_code  = not_supported ? dm_pkg::CmdErrNotSupported : dm_pkg::CmdErrException;
  assign start     = (state_q == StCheck) && !not_supported && !bad_regno;

  // transfer strobes, only in exec and only with transfer set
  assign xfer        = (state_q == StExec) && cmd_q.acc.transfer;
  assign gpr_we      = xfer && cmd_q.acc.write;
  assign gpr_waddr   = gpr_idx[AddrW-1:0];
  assign gpr_raddr   = gpr_idx[AddrW-1:0];
  assign gpr_wdata   = data0_q;
  assign data0_we    = xfer && !cmd_q.acc.write;
  assign data0_wdata = gpr_rdata;

  // the register bank must hold off launches during a command
  no_cmd_when_busy_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cmd_valid |-> !busy
  );

endmodule

`default_nettype wire

// File: hw/abs_timer.sv
// Command latency model. done pulses AbsLatency cycles after start.
`timescale 1ns/10ps
`default_nettype none

module abs_timer #(
  parameter int AbsLatency = 4
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic start,
  output logic      done
);

  localparam int CntW = $clog2(AbsLatency + 1);

  logic [CntW-1:0] count_q;
  logic            running_q;

  assign done = running_q && (count_q == '0);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      running_q <= 1'b0;
      count_q   <= '0;
    end else if (start) begin
      running_q <= 1'b1;
      count_q   <= CntW'(AbsLatency - 1);
    end else if (done) begin
      running_q <= 1'b0;
    end else if (running_q) begin
      count_q <= count_q - 1'b1;
    end
  end

  // engine waits for done before it can restart
  no_restart_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    start |-> !running_q
  );

endmodule

`default_nettype wire

// File: hw/dm_pkg.sv
// Shared types and constants of the debug module: DMI link, register
// access strobes, abstract commands, register addresses and status codes.
`default_nettype none

package dm_pkg;

  // one DMI request as issued by the debug transport
  typedef struct packed {
    logic [6:0]  addr;
    logic [1:0]  op;
    logic [31:0] data;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } dmi_rsp_t;

  localparam logic [1:0] DmiNop   = 2'd0;
  localparam logic [1:0] DmiRead  = 2'd1;
  localparam logic [1:0] DmiWrite = 2'd2;

  localparam logic [1:0] RspSuccess = 2'd0;
  localparam logic [1:0] RspBusy    = 2'd3;

  // debug register addresses
  localparam logic [6:0] AddrData0      = 7'h04;
  localparam logic [6:0] AddrData1      = 7'h05;
  localparam logic [6:0] AddrDmcontrol  = 7'h10;
  localparam logic [6:0] AddrDmstatus   = 7'h11;
  localparam logic [6:0] AddrAbstractcs = 7'h16;
  localparam logic [6:0] AddrCommand    = 7'h17;

  // single-cycle access from the front end into the register bank
  typedef struct packed {
    logic        we;
    logic        re;
    logic [6:0]  addr;
    logic [31:0] wdata;
  } reg_acc_t;

  // access register command layout, cmdtype 0
  typedef struct packed {
    logic [7:0]  cmdtype;
    logic        rsvd_23;
    logic [2:0]  aarsize;
    logic [1:0]  rsvd_19_18;
    logic        transfer;
    logic        write;
    logic [15:0] regno;
  } access_reg_t;

  typedef union packed {
    logic [31:0] raw;
    access_reg_t acc;
  } abs_cmd_u;

  typedef enum logic [2:0] {
    CmdErrNone         = 3'd0,
    CmdErrNotSupported = 3'd2,
    CmdErrException    = 3'd3
  } cmderr_e;

  localparam logic [15:0] GprBase   = 16'h1000;
  localparam logic [3:0]  DmVersion = 4'd2;

endpackage

`default_nettype wire

// File: hw/dm_regs.sv
// Debug register bank. Answers register accesses combinationally, keeps
// data0/data1, dmcontrol and cmderr, and launches abstract commands.
`timescale 1ns/10ps
`default_nettype none

module dm_regs (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire dm_pkg::reg_acc_t reg_acc,
  output logic [31:0]           rdata,
  output logic                  busy_rsp,
  output logic                  cmd_valid,
  output dm_pkg::abs_cmd_u      cmd,
  input  wire logic             busy,
  input  wire logic             err_valid,
  input  wire dm_pkg::cmderr_e  err_code,
  input  wire logic             data0_we,
  input  wire logic [31:0]      data0_wdata,
  output logic [31:0]           data0_q,
  output logic                  ndmreset
);

  logic [31:0]     data1_q;
  logic [1:0]      dmcontrol_q;
  dm_pkg::cmderr_e cmderr_q;
  logic            busy_addr;
  logic            wr_ok;

  // registers that the engine owns while a command runs
  assign busy_addr = (reg_acc.addr == dm_pkg::AddrData0) ||
                     (reg_acc.addr == dm_pkg::AddrData1) ||
                     (reg_acc.addr == dm_pkg::AddrCommand);
  assign busy_rsp  = busy && busy_addr && (reg_acc.we || reg_acc.re);
  assign wr_ok     = reg_acc.we && !busy_rsp;

  always_comb begin
    case (reg_acc.addr)
      dm_pkg::AddrData0:      rdata = data0_q;
      dm_pkg::AddrData1:      rdata = data1_q;
      dm_pkg::AddrDmcontrol:  rdata = {30'h0, dmcontrol_q};
      dm_pkg::AddrDmstatus:   rdata = {24'h0, 1'b1, 3'h0, dm_pkg::DmVersion};
      dm_pkg::AddrAbstractcs: rdata = {19'h0, busy, 1'b0, cmderr_q, 4'h0, 4'd2};
      default:                rdata = 32'h0;
    endcase
  end

  // engine result takes priority over a host write to data0
  always_ff @(posedge clk_i) begin
    if (data0_we) begin
      data0_q <= data0_wdata;
    end else if (wr_ok && reg_acc.addr == dm_pkg::AddrData0) begin
      data0_q <= reg_acc.wdata;
    end
    if (wr_ok && reg_acc.addr == dm_pkg::AddrData1) begin
      data1_q <= reg_acc.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      dmcontrol_q <= 2'b00;
    end else if (wr_ok && reg_acc.addr == dm_pkg::AddrDmcontrol) begin
      dmcontrol_q <= reg_acc.wdata[1:0];
    end
  end

  // cmderr is write-one-to-clear from the host
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cmderr_q <= dm_pkg::CmdErrNone;
    end else if (err_valid) begin
      cmderr_q <= err_code;
    end else if (wr_ok && reg_acc.addr == dm_pkg::AddrAbstractcs) begin
      cmderr_q <= dm_pkg::cmderr_e'(cmderr_q & ~reg_acc.wdata[10:8]);
    end
  end

  // a command only starts with no error pending
  assign cmd_valid = wr_ok && (reg_acc.addr == dm_pkg::AddrCommand) &&
                     (cmderr_q == dm_pkg::CmdErrNone);
  assign cmd.raw   = reg_acc.wdata;

  assign ndmreset = dmcontrol_q[1];

endmodule

`default_nettype wire

// File: hw/dm_top.sv
// Reduced debug module top. Connects the DMI front end, register bank,
// command engine, latency timer and mock hart registers.
`timescale 1ns/10ps
`default_nettype none

module dm_top #(
  parameter int NumGprs    = 8,
  parameter int AbsLatency = 4
) (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             dmi_req_valid,
  input  wire dm_pkg::dmi_req_t dmi_req,
  output logic                  dmi_req_ready,
  output logic                  dmi_rsp_valid,
  output dm_pkg::dmi_rsp_t      dmi_rsp,
  input  wire logic             dmi_rsp_ready,
  output logic                  ndmreset
);

  localparam int GprAddrW = $clog2(NumGprs);

  dm_pkg::reg_acc_t reg_acc;
  logic [31:0]      rdata;
  logic             busy_rsp;
  logic             cmd_valid;
  dm_pkg::abs_cmd_u cmd;
  logic             busy;
  logic             err_valid;
  dm_pkg::cmderr_e  err_code;
  logic             data0_we;
  logic [31:0]      data0_wdata;
  logic [31:0]      data0_q;
  logic             start;
  logic             done;
  logic             gpr_we;
  logic [GprAddrW-1:0] gpr_waddr;
  logic [GprAddrW-1:0] gpr_raddr;
  logic [31:0]      gpr_wdata;
  logic [31:0]      gpr_rdata;

  dmi_front u_dmi_front (
    .clk_i, .rst_ni,
    .dmi_req_valid, .dmi_req, .dmi_req_ready,
    .dmi_rsp_valid, .dmi_rsp, .dmi_rsp_ready,
    .reg_acc, .rdata, .busy_rsp
  );

  dm_regs u_dm_regs (
    .clk_i, .rst_ni,
    .reg_acc, .rdata, .busy_rsp,
    .cmd_valid, .cmd, .busy,
    .err_valid, .err_code,
    .data0_we, .data0_wdata, .data0_q,
    .ndmreset
  );

  abs_cmd_fsm #(.NumGprs(NumGprs)) u_abs_cmd_fsm (
    .clk_i, .rst_ni,
    .cmd_valid, .cmd, .busy,
    .err_valid, .err_code,
    .data0_q, .data0_we, .data0_wdata,
    .start, .done,
    .gpr_we, .gpr_waddr, .gpr_wdata, .gpr_raddr, .gpr_rdata
  );

  abs_timer #(.AbsLatency(AbsLatency)) u_abs_timer (
    .clk_i, .rst_ni, .start, .done
  );

  hart_regfile #(.NumGprs(NumGprs)) u_hart_regfile (
    .clk_i, .rst_ni,
    .we(gpr_we), .waddr(gpr_waddr), .wdata(gpr_wdata),
    .raddr(gpr_raddr), .rdata(gpr_rdata)
  );

endmodule

`default_nettype wire

// File: hw/dmi_front.sv
// DMI target side handshake. Accepts one request at a time, issues a
// register access strobe and holds the response until the host takes it.
`timescale 1ns/10ps
`default_nettype none

module dmi_front (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             dmi_req_valid,
  input  wire dm_pkg::dmi_req_t dmi_req,
  output logic                  dmi_req_ready,
  output logic                  dmi_rsp_valid,
  output dm_pkg::dmi_rsp_t      dmi_rsp,
  input  wire logic             dmi_rsp_ready,
  output dm_pkg::reg_acc_t      reg_acc,
  input  wire logic [31:0]      rdata,
  input  wire logic             busy_rsp
);

  logic             pending_q;
  logic             accept;
  dm_pkg::dmi_rsp_t rsp_q;

  // no new request while a response is outstanding
  assign dmi_req_ready = !pending_q;
  assign accept        = dmi_req_valid && dmi_req_ready;

  always_comb begin
    reg_acc.we    = accept && (dmi_req.op == dm_pkg::DmiWrite);
    reg_acc.re    = accept && (dmi_req.op == dm_pkg::DmiRead);
    reg_acc.addr  = dmi_req.addr;
    reg_acc.wdata = dmi_req.data;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (accept) begin
      pending_q <= 1'b1;
    end else if (dmi_rsp_ready) begin
      pending_q <= 1'b0;
    end
  end

  // response payload, captured from the bank in the accept cycle
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q.data <= reg_acc.re ? rdata : 32'h0;
      rsp_q.resp <= busy_rsp ? dm_pkg::RspBusy : dm_pkg::RspSuccess;
    end
  end

  assign dmi_rsp_valid = pending_q;
  assign dmi_rsp       = rsp_q;

  // host sees a steady response under back-pressure
  rsp_held_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    dmi_rsp_valid && !dmi_rsp_ready |=> dmi_rsp_valid && $stable(dmi_rsp)
  );

endmodule

`default_nettype wire

// File: hw/hart_regfile.sv
// Mock hart general purpose registers, written and read by abstract
// commands. Synchronous write, combinational read.
`timescale 1ns/10ps
`default_nettype none

module hart_regfile #(
  parameter int NumGprs = 8
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       we,
  input  wire logic [$clog2(NumGprs)-1:0] waddr,
  input  wire logic [31:0]                wdata,
  input  wire logic [$clog2(NumGprs)-1:0] raddr,
  output logic [31:0]                     rdata
);

  logic [31:0] regs_q [NumGprs];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumGprs; i++) begin
        regs_q[i] <= 32'h0;
      end
    end else if (we) begin
      regs_q[waddr] <= wdata;
    end
  end

  assign rdata = regs_q[raddr];

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the debug module testbench with Verilator, run it and report the result.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dm_top \
    -f dm_top.f -o tb_dm_top &&
  out="$(./obj_dir/tb_dm_top)" &&
  echo "$out" &&
  echo "$out" | grep -q "^Simulation PASSED$" &&
  echo "run_sim: pass" ||
  { echo "run_sim: fail"; exit 1; }

// File: verification/tb_dm_top.sv
// Table-driven testbench for the reduced debug module. Acts as the DMI host,
// stalls each response for a random number of cycles and checks every reply.
`timescale 1ns/10ps
`default_nettype none

module tb_dm_top;

  localparam int NumGprs    = 8;
  localparam int AbsLatency = 4;

  localparam logic [1:0] OpRd   = dm_pkg::DmiRead;
  localparam logic [1:0] OpWr   = dm_pkg::DmiWrite;
  localparam logic [1:0] RspOk  = dm_pkg::RspSuccess;
  localparam logic [1:0] RspBsy = dm_pkg::RspBusy;

  typedef struct packed {
    logic [1:0]  op;
    logic [6:0]  addr;
    logic [31:0] wdata;
    logic [1:0]  rsp;
    logic [31:0] data;
    logic        poll;
  } entry_t;

  logic             clk_i;
  logic             rst_ni;
  logic             dmi_req_valid;
  dm_pkg::dmi_req_t dmi_req;
  logic             dmi_req_ready;
  logic             dmi_rsp_valid;
  dm_pkg::dmi_rsp_t dmi_rsp;
  logic             dmi_rsp_ready;
  logic             ndmreset;

  entry_t table_q[$];
  int     errors      = 0;
  int     cycles      = 0;
  int     cycle_limit = 0;

  dm_top #(.NumGprs(NumGprs), .AbsLatency(AbsLatency)) u_dut (
    .clk_i, .rst_ni,
    .dmi_req_valid, .dmi_req, .dmi_req_ready,
    .dmi_rsp_valid, .dmi_rsp, .dmi_rsp_ready,
    .ndmreset
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // run limit, armed once the table length is known
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // access register word, always with transfer set
  function automatic logic [31:0] access_cmd(input logic [2:0] size, input logic write,
                                             input logic [15:0] regno);
    return {8'h00, 1'b0, size, 2'b00, 1'b1, write, regno};
  endfunction

  // abstractcs when idle: cmderr in 10:8, datacount 2
  function automatic logic [31:0] abstractcs_word(input logic [2:0] err);
    return {21'h0, err, 8'h02};
  endfunction

  task automatic add_entry(input logic [1:0] op, input logic [6:0] addr,
                           input logic [31:0] wdata, input logic [1:0] rsp,
                           input logic [31:0] data, input logic poll);
    table_q.push_back('{op: op, addr: addr, wdata: wdata, rsp: rsp, data: data, poll: poll});
  endtask

  task automatic expect_write(input logic [6:0] addr, input logic [31:0] wdata,
                              input logic [1:0] rsp);
    add_entry(OpWr, addr, wdata, rsp, 32'h0, 1'b0);
  endtask

  task automatic expect_read(input logic [6:0] addr, input logic [31:0] data);
    add_entry(OpRd, addr, 32'h0, RspOk, data, 1'b0);
  endtask

  task automatic expect_idle(input logic [2:0] err);
    add_entry(OpRd, dm_pkg::AddrAbstractcs, 32'h0, RspOk, abstractcs_word(err), 1'b1);
  endtask

  task automatic build_table();
    // plain registers and ndmreset
    expect_write(dm_pkg::AddrData0, 32'h1234_5678, RspOk);
    expect_read(dm_pkg::AddrData0, 32'h1234_5678);
    expect_write(dm_pkg::AddrData1, 32'hcafe_0001, RspOk);
    expect_read(dm_pkg::AddrData1, 32'hcafe_0001);
    // version 2, authenticated in bit 7
    expect_read(dm_pkg::AddrDmstatus, 32'h0000_0082);
    expect_read(dm_pkg::AddrAbstractcs, abstractcs_word(3'd0));
    expect_write(dm_pkg::AddrDmcontrol, 32'h0000_0003, RspOk);
    expect_read(dm_pkg::AddrDmcontrol, 32'h0000_0003);
    expect_write(dm_pkg::AddrDmcontrol, 32'h0000_0001, RspOk);
    expect_read(dm_pkg::AddrDmcontrol, 32'h0000_0001);
    // write hart reg 3, reload data0, read reg 3 back
    expect_write(dm_pkg::AddrData0, 32'ha5a5_0003, RspOk);
    expect_write(dm_pkg::AddrCommand, access_cmd(3'd2, 1'b1, 16'h1003), RspOk);
    expect_idle(3'd0);
    expect_write(dm_pkg::AddrData0, 32'h0bad_f00d, RspOk);
    expect_write(dm_pkg::AddrCommand, access_cmd(3'd2, 1'b0, 16'h1003), RspOk);
    expect_idle(3'd0);
    expect_read(dm_pkg::AddrData0, 32'ha5a5_0003);
    expect_write(dm_pkg::AddrCommand, access_cmd(3'd2, 1'b0, 16'h1000), RspOk);
    expect_idle(3'd0);
    expect_read(dm_pkg::AddrData0, 32'h0);
    expect_write(dm_pkg::AddrCommand, access_cmd(3'd2, 1'b0, 16'h1007), RspOk);
    expect_idle(3'd0);
    expect_read(dm_pkg::AddrData0, 32'h0);
    // data0 write during a command is refused
    expect_write(dm_pkg::AddrData0, 32'h5555_aaaa, RspOk);
    expect_write(dm_pkg::AddrCommand, access_cmd(3'd2, 1'b1, 16'h1005), RspOk);
    expect_write(dm_pkg::AddrData0, 32'hdead_beef, RspBsy);
    expect_idle(3'd0);
    expect_read(dm_pkg::AddrData0, 32'h5555_aaaa);
    // regno one past the last register
    expect_write(dm_pkg::AddrCommand, access_cmd(3'd2, 1'b1, 16'h1000 + 16'(NumGprs)),
                 RspOk);
    expect_idle(3'd3);
    expect_write(dm_pkg::AddrData0, 32'h1111_2222, RspOk);
    expect_write(dm_pkg::AddrCommand, access_cmd(3'd2, 1'b0, 16'h1003), RspOk);
    expect_idle(3'd3);
    expect_read(dm_pkg::AddrData0, 32'h1111_2222);
    expect_write(dm_pkg::AddrAbstractcs, 32'h0000_0700, RspOk);
    expect_read(dm_pkg::AddrAbstractcs, abstractcs_word(3'd0));
    // unsupported size
    expect_write(dm_pkg::AddrCommand, access_cmd(3'd3, 1'b1, 16'h1003), RspOk);
    expect_idle(3'd2);
    expect_write(dm_pkg::AddrAbstractcs, 32'h0000_0700, RspOk);
    expect_read(dm_pkg::AddrAbstractcs, abstractcs_word(3'd0));
    // reg 3 untouched by the rejected commands
    expect_write(dm_pkg::AddrCommand, access_cmd(3'd2, 1'b0, 16'h1003), RspOk);
    expect_idle(3'd0);
    expect_read(dm_pkg::AddrData0, 32'ha5a5_0003);
  endtask

  // one DMI request and response; entered and left just after a rising edge
  task automatic dmi_transfer(input logic [1:0] op, input logic [6:0] addr,
                              input logic [31:0] wdata, input int stall,
                              output dm_pkg::dmi_rsp_t rsp);
    dm_pkg::dmi_rsp_t held;
    dmi_req_valid <= 1'b1;
    dmi_req       <= '{addr: addr, op: op, data: wdata};
    @(negedge clk_i);
    while (!dmi_req_ready) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    dmi_req_valid <= 1'b0;
    @(negedge clk_i);
    while (!dmi_rsp_valid) begin
      @(negedge clk_i);
    end
    held = dmi_rsp;
    for (int i = 0; i < stall; i++) begin
      @(negedge clk_i);
      if (!dmi_rsp_valid || dmi_rsp !== held || dmi_req_ready) begin
        $display("ERROR %0t: response not held while dmi_rsp_ready is low", $time);
        errors++;
      end
    end
    @(posedge clk_i);
    dmi_rsp_ready <= 1'b1;
    @(posedge clk_i);
    dmi_rsp_ready <= 1'b0;
    rsp = held;
  endtask

  initial begin
    entry_t           e;
    dm_pkg::dmi_rsp_t rsp;
    int unsigned      seed_val;
    int               stall;
    int               polls;
    int               errs_before;
    int               passed;
    int               failed;
    logic             exp_ndmreset;
    seed_val      = $urandom(32'hec76_caa4);
    rst_ni        = 1'b0;
    dmi_req_valid = 1'b0;
    dmi_req       = '0;
    dmi_rsp_ready = 1'b0;
    passed        = 0;
    failed        = 0;
    exp_ndmreset  = 1'b0;
    build_table();
    cycle_limit = table_q.size() * (AbsLatency + 8 + 20 * 10);
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (dmi_rsp_valid || !dmi_req_ready || ndmreset) begin
      $display("ERROR %0t: DMI or ndmreset not idle after reset", $time);
      errors++;
    end
    @(posedge clk_i);
    foreach (table_q[i]) begin
      e           = table_q[i];
      errs_before = errors;
      polls       = 0;
      do begin
        // command writes go out unstalled so the next access lands while busy
        stall = (e.op == OpWr && e.addr == dm_pkg::AddrCommand) ? 0 : int'($urandom % 8);
        dmi_transfer(e.op, e.addr, e.wdata, stall, rsp);
        polls++;
      end while (e.poll && rsp.data[12] && polls < 20);
      if (e.poll && rsp.data[12]) begin
        $display("test %0d: abstractcs still busy after 20 polls", i);
        errors++;
      end
      if (rsp.resp !== e.rsp || rsp.data !== e.data) begin
        $display("ERROR %0t: test %0d addr %h got resp %0d data %h, expected resp %0d data %h",
                 $time, i, e.addr, rsp.resp, rsp.data, e.rsp, e.data);
        errors++;
      end
      if (e.op == OpWr && e.addr == dm_pkg::AddrDmcontrol && e.rsp == RspOk) begin
        exp_ndmreset = e.wdata[1];
      end
      if (ndmreset !== exp_ndmreset) begin
        $display("ERROR %0t: test %0d ndmreset is %b, expected %b",
                 $time, i, ndmreset, exp_ndmreset);
        errors++;
      end
      if (errors == errs_before) begin
        passed++;
      end else begin
        failed++;
      end
      $display("test %0d op %0d addr %h: %s", i, e.op, e.addr,
               (errors == errs_before) ? "ok" : "mismatch");
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             table_q.size(), passed, failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
